/* rv32i_dec.f */
+incdir+rtl
+incdir+tests
rtl/rv32i_dec_pkg.sv
rtl/imm_gen.sv
rtl/alu_ctrl_dec.sv
rtl/ctrl_dec.sv
rtl/decode_reg.sv
rtl/mem_access_unit.sv
rtl/rv32i_decode_stage.sv
tests/tb_rv32i_decode_stage.sv

/* Makefile */
# Verilator build and run of the RV32I decode stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_rv32i_decode_stage
RTL_TOP    ?= rv32i_decode_stage
FILELIST   ?= rv32i_dec.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/decode_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode reference model
// Expected immediate, ALU control, decoded bundle and memory-side outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic word_t build_imm(input inst_t i);
   logic [4:0] op;
   op = i[6:2];
   case (op)
      // Shift immediates keep only the unsigned shift amount
      `OP_IMM:
         return (i[13:12] == 2'b01) ? {27'b0, i[24:20]} : {{20{i[31]}}, i[31:20]};
      `OP_JALR, `OP_LOAD, `OP_MISC_MEM, `OP_SYSTEM:
         return {{20{i[31]}}, i[31:20]};
      `OP_LUI, `OP_AUIPC:
         return {i[31:12], 12'b0};
      `OP_JAL:
         return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      `OP_BRANCH:
         return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      `OP_STORE:
         return {{20{i[31]}}, i[31:25], i[11:7]};
      default:
         return '0;
   endcase
endfunction

function automatic alu_ctrl_t pick_alu(input inst_t i);
   alu_ctrl_t  a;
   logic [4:0] op;
   logic       reg_form;
   op       = i[6:2];
   reg_form = (op == `OP_OP);
   a.op        = ALU_UNKN;
   a.sel1      = SEL1_RS1;
   a.sel2      = SEL2_UNKN;
   a.is_signed = 1'b1;
   if (op == `OP_OP || op == `OP_IMM) begin
      a.sel2 = reg_form ? SEL2_RS2 : SEL2_IMM;
      case (i[14:12])
         3'b000: a.op = (reg_form && i[30]) ? ALU_SUB : ALU_ADD;
         3'b001: a.op = ALU_SLL;
         3'b010: a.op = ALU_SLT;
         3'b011: begin
            a.op        = ALU_SLT;
            a.is_signed = 1'b0;
         end
         3'b100: a.op = ALU_XOR;
         3'b101: a.op = i[30] ? ALU_SRA : ALU_SRL;
         3'b110: a.op = ALU_OR;
         default: a.op = ALU_AND;
      endcase
   end else if (op == `OP_LUI) begin
      a.op   = ALU_ADD;
      a.sel2 = SEL2_IMM;
   end else if (op == `OP_AUIPC) begin
      a.op   = ALU_ADD;
      a.sel1 = SEL1_PC;
      a.sel2 = SEL2_IMM;
   end else if (op == `OP_JAL || op == `OP_JALR) begin
      a.op   = ALU_ADD;
      a.sel2 = SEL2_RS2;
   end
   return a;
endfunction

function automatic dec_ctrl_t decode_inst(input inst_t i, input logic bubble);
   dec_ctrl_t  d;
   logic [4:0] op;
   logic [2:0] f3;
   logic [6:0] f7;
   op = i[6:2];
   f3 = i[14:12];
   f7 = i[31:25];
   d        = '0;
   d.imm    = build_imm(i);
   d.alu    = pick_alu(i);
   d.rs1    = (op == `OP_LUI) ? 5'd0 : i[19:15];
   d.rs2    = i[24:20];
   d.rd     = i[11:7];
   d.funct3 = f3;
   if (bubble) begin
      // Idle ALU code, all strobes low
      d.alu.op        = ALU_UNKN;
      d.alu.sel1      = SEL1_RS1;
      d.alu.sel2      = SEL2_UNKN;
      d.alu.is_signed = 1'b1;
      return d;
   end
   d.regwrite = op inside {`OP_IMM, `OP_OP, `OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_LOAD};
   d.jump     = (op == `OP_JAL);
   d.jr       = (op == `OP_JALR);
   d.link     = d.jump | d.jr;
   d.br       = (op == `OP_BRANCH);
   if (d.br && f3 inside {3'b010, 3'b011}) begin
      d.exc_illegal = 1'b1;
   end
   if (op == `OP_LOAD) begin
      if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
         d.mem.is_load   = 1'b1;
         d.mem.size      = f3[1:0];
         d.mem.is_signed = ~f3[2];
      end else begin
         d.exc_illegal = 1'b1;
      end
   end
   if (op == `OP_STORE) begin
      if (f3 inside {3'b000, 3'b001, 3'b010}) begin
         d.mem.is_store = 1'b1;
         d.mem.size     = f3[1:0];
      end else begin
         d.exc_illegal = 1'b1;
      end
   end
   if (op == `OP_SYSTEM) begin
      if (f3 == 3'b000) begin
         if (f7 == 7'b0) begin
            d.exc_ecall  = ~d.imm[0];
            d.exc_ebreak = d.imm[0];
         end else if (f7 == `FUNCT7_MRET) begin
            d.pc_update = 1'b1;
            d.pc_mepc   = 1'b1;
         end else begin
            d.exc_illegal = 1'b1;
         end
      end else if (f3 == 3'b100) begin
         d.exc_illegal = 1'b1;
      end else begin
         d.regwrite  = 1'b1;
         d.csr_read  = 1'b1;
         d.csr_imm   = f3[2];
         d.csr_write = (f3[1:0] == 2'b01);
         d.csr_set   = (f3[1:0] == 2'b10);
         d.csr_clear = (f3[1:0] == 2'b11);
      end
   end
   if (!(op inside {`OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH, `OP_LOAD,
                    `OP_STORE, `OP_IMM, `OP_OP, `OP_MISC_MEM, `OP_SYSTEM})) begin
      d.exc_unsupported = 1'b1;
   end
   if (d.exc_illegal || d.exc_unsupported) begin
      d.regwrite = 1'b0;
   end
   return d;
endfunction

// Memory outputs of a registered descriptor at a given address offset
function automatic void resolve_mem(input mem_op_t m, input logic rw_in, input addr_lo_t a,
                                    output byte_en_t be, output logic we,
                                    output logic ld_mis, output logic st_mis,
                                    output logic rw_out);
   logic mis;
   be  = 4'b0000;
   mis = 1'b0;
   if (m.is_load || m.is_store) begin
      if (m.size == `MEM_SIZE_BYTE) begin
         be = 4'b0001 << a;
      end else if (m.size == `MEM_SIZE_HALF) begin
         mis = a[0];
         if (!a[0]) begin
            be = a[1] ? 4'b1100 : 4'b0011;
         end
      end else begin
         mis = (a != 2'b00);
         be  = 4'b1111;
      end
   end
   we     = m.is_store;
   ld_mis = m.is_load & mis;
   st_mis = m.is_store & mis;
   rw_out = rw_in & ~ld_mis;
endfunction

`endif

/* tests/tb_rv32i_decode_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode stage testbench
// Random instructions from a fixed seed, checked each cycle against a
// reference model delayed by the one-cycle decode register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_dec_macros.svh"

module tb_rv32i_decode_stage import rv32i_dec_pkg::*; ();

   localparam int NUM_INST     = 2000;
   localparam int RESET_CYCLES = 10;
   localparam int CLK_PERIOD   = 100;
   localparam int TIMEOUT_NS   = (NUM_INST + RESET_CYCLES + 50) * CLK_PERIOD;

   logic      clk;
   logic      rst_n;
   logic      fd_bubble;
   inst_t     inst;
   addr_lo_t  addr_lo;
   dec_ctrl_t dec_q;
   byte_en_t  dm_be;
   logic      dm_we;
   logic      regwrite;
   logic      exc_load_misaligned;
   logic      exc_store_misaligned;

   int        seed;
   int        cycle;
   // Expected bundle for the inputs now driven, and for the register output
   dec_ctrl_t exp_next;
   dec_ctrl_t exp_q;

   `include "decode_model.svh"

   rv32i_decode_stage UUT (
      .clk                  (clk),
      .rst_n                (rst_n),
      .fd_bubble            (fd_bubble),
      .inst                 (inst),
      .addr_lo              (addr_lo),
      .dec_q                (dec_q),
      .dm_be                (dm_be),
      .dm_we                (dm_we),
      .regwrite             (regwrite),
      .exc_load_misaligned  (exc_load_misaligned),
      .exc_store_misaligned (exc_store_misaligned)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [4:0] supported_op(input int n);
      case (n)
         0:       return `OP_LUI;
         1:       return `OP_AUIPC;
         2:       return `OP_JAL;
         3:       return `OP_JALR;
         4:       return `OP_BRANCH;
         5:       return `OP_LOAD;
         6:       return `OP_STORE;
         7:       return `OP_IMM;
         8:       return `OP_OP;
         9:       return `OP_MISC_MEM;
         default: return `OP_SYSTEM;
      endcase
   endfunction

   task check_value(input string name, input logic [127:0] expected,
                    input logic [127:0] actual);
      if (actual !== expected) begin
         $display("error: %s at cycle %0d expected %0h actual %0h",
                  name, cycle, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task random_stimulus(output inst_t i, output logic bubble, output addr_lo_t a);
      logic [31:0] r;
      i = $random(seed);
      // Mostly legal opcodes, sometimes a raw word
      if (({$random(seed)} % 10) != 0) begin
         i[6:0] = {supported_op({$random(seed)} % 11), 2'b11};
         // Steer SYSTEM toward ECALL, EBREAK and MRET encodings
         if (i[6:2] == `OP_SYSTEM && ({$random(seed)} % 2) == 0) begin
            i[14:12] = 3'b000;
            i[31:25] = (({$random(seed)} % 2) == 0) ? 7'b0 : `FUNCT7_MRET;
         end
      end
      r      = $random(seed);
      a      = r[1:0];
      bubble = (({$random(seed)} % 10) == 0);
   endtask

   task compare_outputs(input addr_lo_t a);
      byte_en_t be;
      logic     we;
      logic     ld_mis;
      logic     st_mis;
      logic     rw;
      resolve_mem(exp_q.mem, exp_q.regwrite, a, be, we, ld_mis, st_mis, rw);
      check_value("imm", 128'(exp_q.imm), 128'(dec_q.imm));
      check_value("alu", 128'(exp_q.alu), 128'(dec_q.alu));
      check_value("mem_op", 128'(exp_q.mem), 128'(dec_q.mem));
      check_value("flow", 128'({exp_q.regwrite, exp_q.jump, exp_q.link, exp_q.jr, exp_q.br,
                                exp_q.pc_update, exp_q.pc_mepc}),
                  128'({dec_q.regwrite, dec_q.jump, dec_q.link, dec_q.jr, dec_q.br,
                        dec_q.pc_update, dec_q.pc_mepc}));
      check_value("csr", 128'({exp_q.csr_read, exp_q.csr_write, exp_q.csr_set,
                               exp_q.csr_clear, exp_q.csr_imm}),
                  128'({dec_q.csr_read, dec_q.csr_write, dec_q.csr_set,
                        dec_q.csr_clear, dec_q.csr_imm}));
      check_value("exceptions", 128'({exp_q.exc_illegal, exp_q.exc_unsupported,
                                      exp_q.exc_ecall, exp_q.exc_ebreak}),
                  128'({dec_q.exc_illegal, dec_q.exc_unsupported,
                        dec_q.exc_ecall, dec_q.exc_ebreak}));
      check_value("fields", 128'({exp_q.rs1, exp_q.rs2, exp_q.rd, exp_q.funct3}),
                  128'({dec_q.rs1, dec_q.rs2, dec_q.rd, dec_q.funct3}));
      check_value("dm_be", 128'(be), 128'(dm_be));
      check_value("dm_we", 128'(we), 128'(dm_we));
      check_value("exc_load_misaligned", 128'(ld_mis), 128'(exc_load_misaligned));
      check_value("exc_store_misaligned", 128'(st_mis), 128'(exc_store_misaligned));
      check_value("regwrite", 128'(rw), 128'(regwrite));
   endtask

   // One clock: drive new inputs at the rising edge, check at the falling edge
   task drive_cycle(input logic hold_reset);
      inst_t    next_inst;
      logic     next_bubble;
      addr_lo_t next_addr;
      @(posedge clk);
      cycle = cycle + 1;
      // Register still in reset at this edge if rst_n reads low
      exp_q = (rst_n === 1'b1) ? exp_next : '0;
      if (!hold_reset) begin
         rst_n <= 1'b1;
      end
      random_stimulus(next_inst, next_bubble, next_addr);
      inst      <= next_inst;
      fd_bubble <= next_bubble;
      addr_lo   <= next_addr;
      exp_next = decode_inst(next_inst, next_bubble);
      @(negedge clk);
      compare_outputs(next_addr);
   endtask

   initial begin
      seed      = 98;
      cycle     = 0;
      clk       = 1'b0;
      rst_n     = 1'b0;
      fd_bubble = 1'b0;
      inst      = '0;
      addr_lo   = '0;
      exp_next  = '0;
      exp_q     = '0;
      repeat (RESET_CYCLES) drive_cycle(1'b1);
      repeat (NUM_INST) drive_cycle(1'b0);
      $display("Checked %0d instructions after reset", NUM_INST);
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
      $display("*** FAILED ***");
      $fatal(1, "Watchdog expired");
   end

endmodule

/* rtl/rv32i_decode_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode stage
// Parallel combinational decode, one register stage, then address
// dependent memory controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rv32i_decode_stage import rv32i_dec_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      fd_bubble,
   input  inst_t     inst,
   input  addr_lo_t  addr_lo,
   output dec_ctrl_t dec_q,
   output byte_en_t  dm_be,
   output logic      dm_we,
   output logic      regwrite,
   output logic      exc_load_misaligned,
   output logic      exc_store_misaligned
);

   word_t     imm;
   alu_ctrl_t alu;
   dec_ctrl_t dec_d;

   imm_gen u_imm_gen (
      .inst (inst),
      .imm  (imm)
   );

   alu_ctrl_dec u_alu_ctrl_dec (
      .inst (inst),
      .alu  (alu)
   );

   ctrl_dec u_ctrl_dec (
      .inst      (inst),
      .fd_bubble (fd_bubble),
      .imm       (imm),
      .alu       (alu),
      .dec       (dec_d)
   );

   decode_reg u_decode_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .dec_d (dec_d),
      .dec_q (dec_q)
   );

   // Address arrives with the registered instruction
   mem_access_unit u_mem_access_unit (
      .mem                  (dec_q.mem),
      .regwrite_dec         (dec_q.regwrite),
      .addr_lo              (addr_lo),
      .dm_be                (dm_be),
      .dm_we                (dm_we),
      .exc_load_misaligned  (exc_load_misaligned),
      .exc_store_misaligned (exc_store_misaligned),
      .regwrite             (regwrite)
   );

endmodule

/* rtl/mem_access_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory access unit
// Turns the registered load/store descriptor and the low address bits
// into byte enables, write enable and misalignment exceptions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_dec_macros.svh"

module mem_access_unit import rv32i_dec_pkg::*; (
   input  mem_op_t  mem,
   input  logic     regwrite_dec,
   input  addr_lo_t addr_lo,
   output byte_en_t dm_be,
   output logic     dm_we,
   output logic     exc_load_misaligned,
   output logic     exc_store_misaligned,
   output logic     regwrite
);

   logic access;
   logic misaligned;

   assign access = mem.is_load | mem.is_store;

   always_comb begin
      dm_be      = '0;
      misaligned = 1'b0;
      if (access) begin
         case (mem.size)
            // One lane picked by the address
            `MEM_SIZE_BYTE: dm_be = 4'b0001 << addr_lo;
            `MEM_SIZE_HALF: begin
               misaligned = addr_lo[0];
               dm_be      = addr_lo[0] ? 4'b0000 : (addr_lo[1] ? 4'b1100 : 4'b0011);
            end
            `MEM_SIZE_WORD: begin
               misaligned = |addr_lo;
               dm_be      = 4'b1111;
            end
            default: dm_be = 4'b0000;
         endcase
      end
   end

   assign dm_we                = mem.is_store;
   assign exc_load_misaligned  = mem.is_load & misaligned;
   assign exc_store_misaligned = mem.is_store & misaligned;
   // Faulting load must not write back
   assign regwrite             = regwrite_dec & ~exc_load_misaligned;

   // Descriptor from the decoder is never both load and store
   always_comb begin
      assert final (!(exc_load_misaligned && exc_store_misaligned))
         else $error("mem_access_unit: load and store misaligned together");
   end

endmodule

/* rtl/decode_reg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode pipeline register
// Holds one decoded instruction bundle for the execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_reg import rv32i_dec_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  dec_ctrl_t dec_d,
   output dec_ctrl_t dec_q
);

   // Whole bundle clears so no strobe fires out of reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_q <= '0;
      end else begin
         dec_q <= dec_d;
      end
   end

   // CSR write kinds exclude each other
   a_csr_kind: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0({dec_q.csr_write, dec_q.csr_set, dec_q.csr_clear}))
      else $error("decode_reg: more than one CSR write strobe");

   // Direct and register jumps never coincide
   a_jump_kind: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(dec_q.jump && dec_q.jr))
      else $error("decode_reg: jump and jr both set");

endmodule

/* rtl/ctrl_dec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main control decoder
// Decodes control flow, CSR strobes, the load/store descriptor and the
// decode-time exceptions, and merges everything into one bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_dec_macros.svh"

module ctrl_dec import rv32i_dec_pkg::*; (
   input  inst_t     inst,
   input  logic      fd_bubble,
   input  word_t     imm,
   input  alu_ctrl_t alu,
   output dec_ctrl_t dec
);

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = inst[6:2];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];

   always_comb begin
      dec        = '0;
      dec.imm    = imm;
      dec.rs1    = (opcode == `OP_LUI) ? 5'd0 : inst[19:15];
      dec.rs2    = inst[24:20];
      dec.rd     = inst[11:7];
      dec.funct3 = funct3;
      // A bubble gets the idle ALU setting
      dec.alu    = fd_bubble ? '{op: ALU_UNKN, sel1: SEL1_RS1, sel2: SEL2_UNKN, is_signed: 1'b1}
                             : alu;
      if (!fd_bubble) begin
         case (opcode)
            `OP_IMM, `OP_OP, `OP_LUI, `OP_AUIPC: dec.regwrite = 1'b1;
            `OP_JAL: begin
               dec.jump     = 1'b1;
               dec.link     = 1'b1;
               dec.regwrite = 1'b1;
            end
            `OP_JALR: begin
               dec.jr       = 1'b1;
               dec.link     = 1'b1;
               dec.regwrite = 1'b1;
            end
            `OP_BRANCH: begin
               // Comparator picks the condition from funct3
               dec.br          = 1'b1;
               dec.exc_illegal = (funct3[2:1] == 2'b01);
            end
            `OP_LOAD: begin
               dec.regwrite = 1'b1;
               if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111) begin
                  dec.exc_illegal = 1'b1;
               end else begin
                  dec.mem.is_load   = 1'b1;
                  dec.mem.size      = funct3[1:0];
                  dec.mem.is_signed = ~funct3[2];
               end
            end
            `OP_STORE: begin
               if (funct3[2] || funct3[1:0] == 2'b11) begin
                  dec.exc_illegal = 1'b1;
               end else begin
                  dec.mem.is_store = 1'b1;
                  dec.mem.size     = funct3[1:0];
               end
            end
            `OP_MISC_MEM: begin
               // FENCE is a no-op for an in-order core
               dec.regwrite = 1'b0;
            end
            `OP_SYSTEM: begin
               case (funct3)
                  3'b000: begin
                     if (funct7 == 7'b0) begin
                        // imm[0] separates EBREAK from ECALL
                        dec.exc_ecall  = ~imm[0];
                        dec.exc_ebreak = imm[0];
                     end else if (funct7 == `FUNCT7_MRET) begin
                        dec.pc_update = 1'b1;
                        dec.pc_mepc   = 1'b1;
                     end else begin
                        dec.exc_illegal = 1'b1;
                     end
                  end
                  3'b100: dec.exc_illegal = 1'b1;
                  default: begin
                     // CSRRW/S/C and their immediate forms
                     dec.regwrite  = 1'b1;
                     dec.csr_read  = 1'b1;
                     dec.csr_imm   = funct3[2];
                     dec.csr_write = (funct3[1:0] == 2'b01);
                     dec.csr_set   = (funct3[1:0] == 2'b10);
                     dec.csr_clear = (funct3[1:0] == 2'b11);
                  end
               endcase
            end
            default: dec.exc_unsupported = 1'b1;
         endcase
         if (dec.exc_illegal || dec.exc_unsupported) begin
            dec.regwrite = 1'b0;
         end
      end
   end

endmodule

/* rtl/alu_ctrl_dec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU control decoder
// Selects the ALU operation, both operand sources and signedness
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_dec_macros.svh"

module alu_ctrl_dec import rv32i_dec_pkg::*; (
   input  inst_t     inst,
   output alu_ctrl_t alu
);

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       is_op;

   assign opcode = inst[6:2];
   assign funct3 = inst[14:12];
   assign is_op  = (opcode == `OP_OP);

   always_comb begin
      alu = '{op: ALU_UNKN, sel1: SEL1_RS1, sel2: SEL2_UNKN, is_signed: 1'b1};
      case (opcode)
         `OP_IMM, `OP_OP: begin
            alu.sel2 = is_op ? SEL2_RS2 : SEL2_IMM;
            case (funct3)
               // No SUBI, bit 30 belongs to the immediate there
               3'b000: alu.op = (is_op && inst[30]) ? ALU_SUB : ALU_ADD;
               3'b001: alu.op = ALU_SLL;
               3'b010: alu.op = ALU_SLT;
               3'b011: begin
                  alu.op        = ALU_SLT;
                  alu.is_signed = 1'b0;
               end
               3'b100: alu.op = ALU_XOR;
               3'b101: alu.op = inst[30] ? ALU_SRA : ALU_SRL;
               3'b110: alu.op = ALU_OR;
               default: alu.op = ALU_AND;
            endcase
         end
         `OP_LUI: begin
            // rs1 is forced to x0 so the sum is the immediate
            alu.op   = ALU_ADD;
            alu.sel2 = SEL2_IMM;
         end
         `OP_AUIPC: begin
            alu.op   = ALU_ADD;
            alu.sel1 = SEL1_PC;
            alu.sel2 = SEL2_IMM;
         end
         `OP_JAL, `OP_JALR: begin
            // Link address sum, operands are arranged by execute
            alu.op   = ALU_ADD;
            alu.sel2 = SEL2_RS2;
         end
         default: begin
            alu.op = ALU_UNKN;
         end
      endcase
   end

endmodule

/* rtl/imm_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Immediate generator
// Classifies the opcode into I/U/R/J/B/S format and builds the
// sign-extended immediate of the instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "rv32i_dec_macros.svh"

module imm_gen import rv32i_dec_pkg::*; (
   input  inst_t inst,
   output word_t imm
);

   logic [4:0] opcode;
   // One-hot format, bit order I U R J B S
   logic [5:0] fmt;
   logic       shamt_op;

   assign opcode   = inst[6:2];
   // SLLI, SRLI and SRAI carry a shift amount instead
   assign shamt_op = (opcode == `OP_IMM) && (inst[13:12] == 2'b01);

   always_comb begin
      case (opcode)
         `OP_IMM, `OP_JALR, `OP_LOAD, `OP_MISC_MEM, `OP_SYSTEM: fmt = 6'b100000;
         `OP_LUI, `OP_AUIPC:                                  fmt = 6'b010000;
         `OP_OP:                                              fmt = 6'b001000;
         `OP_JAL:                                             fmt = 6'b000100;
         `OP_BRANCH:                                          fmt = 6'b000010;
         `OP_STORE:                                           fmt = 6'b000001;
         default:                                             fmt = 6'b000000;
      endcase
   end

   always_comb begin
      case (fmt)
         6'b100000: imm = shamt_op ? {27'b0, inst[24:20]} : {{21{inst[31]}}, inst[30:20]};
         6'b010000: imm = {inst[31:12], 12'b0};
         6'b000100: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
         6'b000010: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
         6'b000001: imm = {{21{inst[31]}}, inst[30:25], inst[11:8], inst[7]};
         // R-type and unknown opcodes carry no immediate
         default:   imm = '0;
      endcase
   end

endmodule

/* rtl/rv32i_dec_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode stage types
// Vector typedefs, ALU code enums and the packed bundles passed between
// the decoders, the decode register and the memory access unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "rv32i_dec_macros.svh"

package rv32i_dec_pkg;

   typedef logic [31:0]          inst_t;
   typedef logic [`XLEN-1:0]     word_t;
   typedef logic [4:0]           reg_addr_t;
   typedef logic [`XLEN/8-1:0]   byte_en_t;
   typedef logic [1:0]           addr_lo_t;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SLT  = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SRL  = 4'd5,
      ALU_SRA  = 4'd6,
      ALU_OR   = 4'd7,
      ALU_AND  = 4'd8,
      ALU_UNKN = 4'd15
   } alu_op_e;

   typedef enum logic {
      SEL1_RS1 = 1'b0,
      SEL1_PC  = 1'b1
   } alu_sel1_e;

   typedef enum logic [1:0] {
      SEL2_RS2  = 2'b00,
      SEL2_IMM  = 2'b01,
      SEL2_UNKN = 2'b11
   } alu_sel2_e;

   // Load/store descriptor, resolved against the address one stage later
   typedef struct packed {
      logic       is_load;
      logic       is_store;
      logic [1:0] size;
      logic       is_signed;
   } mem_op_t;

   typedef struct packed {
      alu_op_e   op;
      alu_sel1_e sel1;
      alu_sel2_e sel2;
      logic      is_signed;
   } alu_ctrl_t;

   // One fully decoded instruction
   typedef struct packed {
      word_t     imm;
      alu_ctrl_t alu;
      mem_op_t   mem;
      logic      regwrite;
      logic      jump;
      logic      link;
      logic      jr;
      logic      br;
      logic      pc_update;
      logic      pc_mepc;
      logic      csr_read;
      logic      csr_write;
      logic      csr_set;
      logic      csr_clear;
      logic      csr_imm;
      logic      exc_illegal;
      logic      exc_unsupported;
      logic      exc_ecall;
      logic      exc_ebreak;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      logic [2:0] funct3;
   } dec_ctrl_t;

endpackage

/* rtl/rv32i_dec_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decode constants
// Opcode[6:2] major codes, funct codes, widths and memory access sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RV32I_DEC_MACROS_SVH
`define RV32I_DEC_MACROS_SVH

`define XLEN 32

// Major opcodes, bits [1:0] are always 2'b11
`define OP_LOAD     5'b00000
`define OP_MISC_MEM 5'b00011
`define OP_IMM      5'b00100
`define OP_AUIPC    5'b00101
`define OP_STORE    5'b01000
`define OP_OP       5'b01100
`define OP_LUI      5'b01101
`define OP_BRANCH   5'b11000
`define OP_JALR     5'b11001
`define OP_JAL      5'b11011
`define OP_SYSTEM   5'b11100

// Privileged return
`define FUNCT7_MRET 7'b0011000

// Load/store size, same as funct3[1:0]
`define MEM_SIZE_BYTE 2'b00
`define MEM_SIZE_HALF 2'b01
`define MEM_SIZE_WORD 2'b10

`endif
